// ==== common/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry, two ways of 64 sets
`define ICACHE_N_SETS     64
`define ICACHE_IDX_BITS   6     // log2 of the set count

// an address tag is what is left above the set index
// and the line offset, kept small here
`define ICACHE_TAG_BITS   8

// one line is four 32 bit instructions
`define ICACHE_LINE_BITS  128

// set associativity
`define ICACHE_N_WAYS     2

`endif

// ==== common/icache_pkg.sv ====
`include "icache_macros.svh"

package icache_pkg;

    // set index into every way RAM
    typedef logic [`ICACHE_IDX_BITS-1:0]  icache_idx_t;

    // tag kept per line in the tag RAM
    typedef logic [`ICACHE_TAG_BITS-1:0]  icache_tag_t;

    // full instruction line, filled in one refill beat
    typedef logic [`ICACHE_LINE_BITS-1:0] icache_line_t;

    // one bit per way, one hot
    // used for per way hits, valid bits and write enables
    typedef logic [`ICACHE_N_WAYS-1:0]    icache_way_sel_t;

endpackage

// ==== icache_way/set_ram.sv ====
`timescale 1ns/100ps
`include "icache_macros.svh"

// behavioral single port set RAM
// one word per set, read data one cycle after the request
module set_ram #(
    parameter type payload_t = logic [31:0]  // line or tag word
) (
    input  logic                   clk_i,
    input  logic                   req_i,   // chip enable
    input  logic                   we_i,    // write when high, read when low
    input  icache_pkg::icache_idx_t addr_i,
    input  payload_t               data_i,
    output payload_t               data_o
);

    payload_t mem_q [`ICACHE_N_SETS];  // storage array
    payload_t rd_q;                    // registered read port

    // write goes straight to the array
    // read word shows up after the edge, like a macro
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[addr_i] <= data_i;
            end else begin
                rd_q <= mem_q[addr_i];   // holds until the next read
            end
        end
    end

    assign data_o = rd_q;

endmodule

// ==== icache_way/icache_way.sv ====
`timescale 1ns/100ps
`include "icache_macros.svh"

// one way of the cache
// a line RAM and a tag RAM share the address, valid bits live in flops
module icache_way (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_i,        // lookup strobe
    input  logic                     we_i,         // refill write into this way
    input  logic                     flush_i,      // drop every line
    input  icache_pkg::icache_idx_t  addr_i,       // lookup or refill index
    input  icache_pkg::icache_tag_t  tag_i,        // lookup or refill tag
    input  icache_pkg::icache_line_t data_i,       // refill line
    input  icache_pkg::icache_idx_t  valid_idx_i,  // set probed for victim choice
    output logic                     hit_o,
    output logic                     valid_o,
    output icache_pkg::icache_line_t data_o
);

    import icache_pkg::*;

    logic                       ram_req;      // RAMs enabled on lookup or write
    icache_tag_t                tag_rd;       // stored tag of the looked up set
    logic [`ICACHE_N_SETS-1:0]  valid_q;      // one valid bit per set
    logic                       lkp_valid_q;  // valid bit sampled with the lookup
    icache_tag_t                lkp_tag_q;    // tag to compare against

    assign ram_req = req_i | we_i;

    // line storage
    set_ram #(
        .payload_t (icache_line_t)
    ) u_line_ram (
        .clk_i  (clk_i),
        .req_i  (ram_req),
        .we_i   (we_i),
        .addr_i (addr_i),
        .data_i (data_i),
        .data_o (data_o)     // stale on a miss, masked by the hit select
    );

    // tag storage, same address as the line
    set_ram #(
        .payload_t (icache_tag_t)
    ) u_tag_ram (
        .clk_i  (clk_i),
        .req_i  (ram_req),
        .we_i   (we_i),
        .addr_i (addr_i),
        .data_i (tag_i),
        .data_o (tag_rd)
    );

    // valid bits
    // flush takes priority over a refill in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;           // whole way invalid in one cycle
        end else if (we_i) begin
            valid_q[addr_i] <= 1'b1;
        end
    end

    // sample valid alongside the RAM read so both line up in n+1
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lkp_valid_q <= 1'b0;
        end else if (req_i) begin
            lkp_valid_q <= valid_q[addr_i];
        end
    end

    // compare tag, no reset needed
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            lkp_tag_q <= tag_i;
        end
    end

    // tag compare against the RAM output
    assign hit_o = lkp_valid_q & (tag_rd == lkp_tag_q);

    // straight from flops, used for the victim pick
    assign valid_o = valid_q[valid_idx_i];

endmodule

// ==== design/icache_hit_select.sv ====
`timescale 1ns/100ps
`include "icache_macros.svh"

// merges the per way results and runs replacement
// lru bit per set names the way to evict next
module icache_hit_select (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        req_i,         // lookup strobe, cycle n
    input  logic                        refill_i,      // refill strobe
    input  icache_pkg::icache_idx_t     req_idx_i,
    input  icache_pkg::icache_idx_t     refill_idx_i,
    input  icache_pkg::icache_way_sel_t way_hit_i,     // per way hit, cycle n+1
    input  icache_pkg::icache_way_sel_t way_valid_i,   // valid bits at refill_idx_i
    input  icache_pkg::icache_line_t    way0_line_i,
    input  icache_pkg::icache_line_t    way1_line_i,
    output icache_pkg::icache_way_sel_t way_we_o,      // one hot refill target
    output logic                        rsp_valid_o,
    output logic                        hit_o,
    output icache_pkg::icache_line_t    line_o
);

    import icache_pkg::*;

    logic                       req_q;     // lookup in flight
    icache_idx_t                idx_q;     // its set index
    logic [`ICACHE_N_SETS-1:0]  lru_q;     // 0 evicts way 0, 1 evicts way 1
    logic                       any_hit;
    icache_way_sel_t            victim;

    // request pipeline stage
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            idx_q <= req_idx_i;    // payload only
        end
    end

    assign any_hit = req_q & (|way_hit_i);

    // response side, all combinational in n+1
    assign rsp_valid_o = req_q;
    assign hit_o       = any_hit;

    always_comb begin
        line_o = '0;                        // miss returns zeros
        if (req_q) begin
            if (way_hit_i[0]) begin
                line_o = way0_line_i;       // way 0 wins a double hit
            end else if (way_hit_i[1]) begin
                line_o = way1_line_i;
            end
        end
    end

    // victim pick
    // an empty way first, else the lru way
    always_comb begin
        if (!way_valid_i[0]) begin
            victim = 2'b01;
        end else if (!way_valid_i[1]) begin
            victim = 2'b10;
        end else begin
            victim = lru_q[refill_idx_i] ? 2'b10 : 2'b01;
        end
    end

    assign way_we_o = refill_i ? victim : '0;

    // lru update, refill overrides a hit on the same set
    // flush leaves these alone
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lru_q <= '0;
        end else begin
            if (any_hit) begin
                lru_q[idx_q] <= way_hit_i[0];       // point at the other way
            end
            if (refill_i) begin
                lru_q[refill_idx_i] <= victim[0];   // evict the unwritten one next
            end
        end
    end

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/100ps

// two way set associative icache lookup and refill datapath
module icache_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_i,          // lookup strobe
    input  logic                     refill_i,       // refill strobe
    input  logic                     flush_i,        // invalidate all
    input  icache_pkg::icache_idx_t  req_idx_i,
    input  icache_pkg::icache_idx_t  refill_idx_i,
    input  icache_pkg::icache_tag_t  req_tag_i,
    input  icache_pkg::icache_tag_t  refill_tag_i,
    input  icache_pkg::icache_line_t refill_line_i,
    output logic                     rsp_valid_o,    // one cycle after req_i
    output logic                     hit_o,
    output icache_pkg::icache_line_t line_o
);

    import icache_pkg::*;

    icache_idx_t     way_addr;     // shared RAM address
    icache_tag_t     way_tag;      // shared tag, compare or write
    icache_way_sel_t way_we;       // refill target
    icache_way_sel_t way_hit;
    icache_way_sel_t way_valid;
    icache_line_t    way0_line;
    icache_line_t    way1_line;

    // refill and lookup never overlap, refill steers the RAM port
    assign way_addr = refill_i ? refill_idx_i : req_idx_i;
    assign way_tag  = refill_i ? refill_tag_i : req_tag_i;

    icache_way u_way0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .we_i        (way_we[0]),
        .flush_i     (flush_i),
        .addr_i      (way_addr),
        .tag_i       (way_tag),
        .data_i      (refill_line_i),
        .valid_idx_i (refill_idx_i),
        .hit_o       (way_hit[0]),
        .valid_o     (way_valid[0]),
        .data_o      (way0_line)
    );

    icache_way u_way1 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .we_i        (way_we[1]),
        .flush_i     (flush_i),
        .addr_i      (way_addr),
        .tag_i       (way_tag),
        .data_i      (refill_line_i),
        .valid_idx_i (refill_idx_i),
        .hit_o       (way_hit[1]),
        .valid_o     (way_valid[1]),
        .data_o      (way1_line)
    );

    // hit merge, lru and victim choice
    icache_hit_select u_hit_select (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .refill_i     (refill_i),
        .req_idx_i    (req_idx_i),
        .refill_idx_i (refill_idx_i),
        .way_hit_i    (way_hit),
        .way_valid_i  (way_valid),
        .way0_line_i  (way0_line),
        .way1_line_i  (way1_line),
        .way_we_o     (way_we),
        .rsp_valid_o  (rsp_valid_o),
        .hit_o        (hit_o),
        .line_o       (line_o)
    );

endmodule

// ==== sim/icache_clk_gen.sv ====
`timescale 1ns/100ps

// free running clock, synchronous reset held low for four cycles
module icache_clk_gen #(
    parameter int PERIOD = 4       // ns
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_n_o <= 1'b1;           // released on an edge like any flop
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== sim/icache_assertions.sv ====
`timescale 1ns/100ps

// port level protocol rules of the cache top
module icache_assertions (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     req_i,
    input logic                     refill_i,
    input logic                     rsp_valid_o,
    input logic                     hit_o,
    input icache_pkg::icache_line_t line_o
);

    // lookup and refill share the RAM port
    a_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(req_i && refill_i))
        else $error("req_i and refill_i high in the same cycle");

    a_rsp_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o == $past(req_i))   // exactly one cycle later
        else $error("rsp_valid_o does not follow req_i by one cycle");

    a_hit_qual: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(hit_o && !rsp_valid_o))
        else $error("hit_o high without rsp_valid_o");

    // a miss must not leak a stale way line
    a_miss_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_o && !hit_o) |-> (line_o == '0))
        else $error("line_o not zero on a miss");

endmodule

// ==== sim/icache_tb.sv ====
`timescale 1ns/100ps

// reads the operation list, drives the cache top and checks every lookup
module icache_tb;

    import icache_pkg::*;

    localparam int CLK_PERIOD = 4;     // ns

    logic         clk;
    logic         rst_n;
    logic         req;
    logic         refill;
    logic         flush;
    icache_idx_t  req_idx;
    icache_idx_t  refill_idx;
    icache_tag_t  req_tag;
    icache_tag_t  refill_tag;
    icache_line_t refill_line;
    logic         rsp_valid;
    logic         hit;
    icache_line_t line;

    // one entry per operation line of the file
    string        name_q[$];
    string        op_q[$];
    icache_idx_t  idx_q[$];
    icache_tag_t  tag_q[$];
    icache_line_t data_q[$];
    logic         exp_hit_q[$];
    icache_line_t exp_line_q[$];
    int           pend_q[$];           // lookups waiting for their response

    int   n_file_lines = 0;
    int   pass_cnt = 0;
    int   fail_cnt = 0;
    bit   loaded = 1'b0;
    bit   test_bad;
    logic rsp_due = 1'b0;              // a response belongs to this cycle

    icache_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    icache_top UUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .req_i         (req),
        .refill_i      (refill),
        .flush_i       (flush),
        .req_idx_i     (req_idx),
        .refill_idx_i  (refill_idx),
        .req_tag_i     (req_tag),
        .refill_tag_i  (refill_tag),
        .refill_line_i (refill_line),
        .rsp_valid_o   (rsp_valid),
        .hit_o         (hit),
        .line_o        (line)
    );

    bind icache_top icache_assertions u_assertions (.*);

    task automatic check_value(input string test_name, input string what,
                               input icache_line_t exp_val, input icache_line_t act_val);
        if (act_val !== exp_val) begin
            $display("** Error: %s %s expected %0h actual %0h", test_name, what, exp_val, act_val);
            test_bad = 1'b1;
        end
    endtask

    task automatic load_tests();
        int           fd;
        int           cnt;
        string        text;
        string        nm;
        string        op;
        icache_idx_t  idx;
        icache_tag_t  tag;
        icache_line_t data;
        logic         eh;
        icache_line_t el;
        fd = $fopen("sim/icache_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/icache_tests.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                cnt = $fgets(text, fd);
                if (cnt > 0) begin
                    n_file_lines++;
                    if (text.substr(0, 0) != "#") begin    // skip comment lines
                        cnt = $sscanf(text, "%s %s %h %h %h %h %h", nm, op, idx, tag, data, eh, el);
                        if (cnt == 7) begin
                            name_q.push_back(nm);
                            op_q.push_back(op);
                            idx_q.push_back(idx);
                            tag_q.push_back(tag);
                            data_q.push_back(data);
                            exp_hit_q.push_back(eh);
                            exp_line_q.push_back(el);
                        end else if (cnt > 0) begin
                            $display("line %0d of the tests file is malformed", n_file_lines);
                            fail_cnt++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one operation per clock, the idle port gets the inverted index and tag
    task automatic drive_op(input int k);
        req         <= (op_q[k] == "lookup");
        refill      <= (op_q[k] == "refill");
        flush       <= (op_q[k] == "flush");
        refill_line <= data_q[k];
        if (op_q[k] == "refill") begin
            refill_idx <= idx_q[k];
            refill_tag <= tag_q[k];
            req_idx    <= ~idx_q[k];       // a wrong port steer lands elsewhere
            req_tag    <= ~tag_q[k];
        end else begin
            req_idx    <= idx_q[k];
            req_tag    <= tag_q[k];
            refill_idx <= ~idx_q[k];
            refill_tag <= ~tag_q[k];
        end
        if (op_q[k] == "lookup") begin
            pend_q.push_back(k);           // checked one cycle later
        end else if (op_q[k] == "refill" || op_q[k] == "flush") begin
            $display("%s %s done", name_q[k], op_q[k]);
            pass_cnt++;
        end else begin
            $display("unknown operation %s in test %s", op_q[k], name_q[k]);
            fail_cnt++;
        end
    endtask

    initial begin
        req         = 1'b0;
        refill      = 1'b0;
        flush       = 1'b0;
        req_idx     = '0;
        refill_idx  = '0;
        req_tag     = '0;
        refill_tag  = '0;
        refill_line = '0;
        load_tests();
        loaded = 1'b1;
        wait (rst_n === 1'b1);
        for (int k = 0; k < name_q.size(); k++) begin
            @(posedge clk);
            drive_op(k);
        end
        @(posedge clk);
        req    <= 1'b0;
        refill <= 1'b0;
        flush  <= 1'b0;
        while (pend_q.size() != 0) @(negedge clk);
        @(posedge clk);                    // let the last report print
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && name_q.size() != 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // responses sampled mid cycle, away from the driving edge
    always @(negedge clk) begin : check_rsp
        int k;
        if (rsp_due && pend_q.size() != 0) begin
            k = pend_q.pop_front();
            test_bad = 1'b0;
            if (rsp_valid !== 1'b1) begin
                $display("no response from the DUT one cycle after lookup %s", name_q[k]);
                test_bad = 1'b1;
            end else begin
                check_value(name_q[k], "hit", exp_hit_q[k], hit);
                check_value(name_q[k], "line", exp_line_q[k], line);
            end
            if (test_bad) begin
                fail_cnt++;
                $display("%s failed", name_q[k]);
            end else begin
                pass_cnt++;
                $display("%s passed", name_q[k]);
            end
        end else if (rst_n === 1'b1 && (rsp_valid !== 1'b0 || hit !== 1'b0)) begin
            // nothing was looked up one cycle ago
            $display("rsp_valid_o or hit_o high in a cycle with no lookup pending");
            fail_cnt++;
        end
        rsp_due = req;
    end

    // watchdog, four cycles per file line plus slack
    initial begin
        wait (loaded);
        #((n_file_lines * 4 + 100) * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sim/icache_tests.txt ====
# name op idx tag line exp_hit exp_line, fields after op in hex, 0 where unused
# one operation per clock, a lookup is checked in the following cycle
cold_a       lookup 00 00 0 0 0
cold_b       lookup 15 3c 0 0 0
cold_c       lookup 3f ff 0 0 0
fill_one     refill 01 11 00112233445566778899aabbccddeeff 0 0
hit_one      lookup 01 11 0 1 00112233445566778899aabbccddeeff
miss_tag     lookup 01 22 0 0 0
fill_w0      refill 02 0a 0a0a0a0a111111112222222233333333 0 0
fill_w1      refill 02 0b 0b0b0b0b444444445555555566666666 0 0
hit_w0       lookup 02 0a 0 1 0a0a0a0a111111112222222233333333
hit_w1       lookup 02 0b 0 1 0b0b0b0b444444445555555566666666
hit_w0_again lookup 02 0a 0 1 0a0a0a0a111111112222222233333333
fill_a       refill 03 a0 a0a0a0a0deadbeef0000000012345678 0 0
fill_b       refill 03 b0 b0b0b0b0cafef00d1111111187654321 0 0
touch_a      lookup 03 a0 0 1 a0a0a0a0deadbeef0000000012345678
gap          lookup 20 a0 0 0 0
fill_c       refill 03 c0 c0c0c0c0feedface22222222aaaa5555 0 0
lru_a        lookup 03 a0 0 1 a0a0a0a0deadbeef0000000012345678
lru_b        lookup 03 b0 0 0 0
lru_c        lookup 03 c0 0 1 c0c0c0c0feedface22222222aaaa5555
flush_all    flush  00 00 0 0 0
fl_one       lookup 01 11 0 0 0
fl_w0        lookup 02 0a 0 0 0
fl_w1        lookup 02 0b 0 0 0
fl_c         lookup 03 c0 0 0 0
refill_new   refill 01 11 5a5a5a5a0f0f0f0f7777777788888888 0 0
hit_new      lookup 01 11 0 1 5a5a5a5a0f0f0f0f7777777788888888

// ==== icache.f ====
+incdir+common
common/icache_pkg.sv
icache_way/set_ram.sv
icache_way/icache_way.sv
design/icache_hit_select.sv
design/icache_top.sv
sim/icache_clk_gen.sv
sim/icache_assertions.sv
sim/icache_tb.sv
